/* hdl/cgra_cfg.svh */
`ifndef CGRA_CFG_SVH
`define CGRA_CFG_SVH

// datapath word and bank address widths
`define CGRA_WORD_W      32
`define CGRA_ADDR_W      8

// scratchpad size, one word per address
`define CGRA_BANK_DEPTH  256

// processing elements in one row, edge element included
`define CGRA_ROW_PES     4

`endif

/* hdl/cgra_types_pkg.sv */
`include "cgra_cfg.svh"

package cgra_types_pkg;

    typedef logic [`CGRA_WORD_W-1:0] word_t;
    typedef logic [`CGRA_ADDR_W-1:0] addr_t;
    typedef logic [`CGRA_WORD_W-1:0] cfg_word_t;   // shared config word

    // north or south words of the whole row
    typedef struct packed {
        word_t pe3;
        word_t pe2;
        word_t pe1;
        word_t pe0;
    } row_edge_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } bank_req_t;

endpackage

/* hdl/cgra_isa_pkg.sv */
package cgra_isa_pkg;

    import cgra_types_pkg::*;

    typedef enum logic [2:0] {
        op_pass, op_add, op_sub, op_mul, op_and, op_or, op_xor
    } pe_op_e;

    typedef enum logic [2:0] {
        sel_n, sel_s, sel_w, sel_e, sel_self
    } port_sel_e;

    typedef enum logic [1:0] {
        lsu_idle, lsu_load, lsu_store
    } lsu_mode_e;

    // cfg word bits 31:19
    typedef struct packed {
        pe_op_e    op;
        port_sel_e src_a;
        port_sel_e src_b;
        logic [3:0] out_mask;   // N S W E, msb first
    } pe_inst_t;

    // cfg word bits 17:0
    typedef struct packed {
        lsu_mode_e mode;
        addr_t     base;
        addr_t     stride;
    } lsu_inst_t;

    localparam int mask_n = 3;
    localparam int mask_s = 2;
    localparam int mask_w = 1;
    localparam int mask_e = 0;

    function automatic word_t pe_pick(port_sel_e sel, word_t n, word_t s, word_t w,
                                      word_t e, word_t self);
        case (sel)
            sel_n:    return n;
            sel_s:    return s;
            sel_w:    return w;
            sel_e:    return e;
            sel_self: return self;   // own previous result
            default:  return '0;
        endcase
    endfunction

    function automatic word_t pe_alu(pe_op_e op, word_t a, word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_mul:  return a * b;     // low word only
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            default: return a;         // pass
        endcase
    endfunction

endpackage

/* hdl/pe_d.sv */
`timescale 1ns/1ps

module pe_d
    import cgra_types_pkg::*;
    import cgra_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      init,
    input  logic      run,
    input  cfg_word_t inst_in,
    input  word_t     din_n,
    input  word_t     din_s,
    input  word_t     din_w,
    input  word_t     din_e,
    output word_t     dout_n,
    output word_t     dout_s,
    output word_t     dout_w,
    output word_t     dout_e
);

    pe_inst_t inst;
    word_t    res;
    word_t    opa;
    word_t    opb;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst <= '0;
        end else if (init) begin
            inst <= inst_in[$bits(cfg_word_t)-1 -: $bits(pe_inst_t)];   // upper slice
        end
    end

    assign opa = pe_pick(inst.src_a, din_n, din_s, din_w, din_e, res);
    assign opb = pe_pick(inst.src_b, din_n, din_s, din_w, din_e, res);

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else if (run) begin
            res <= pe_alu(inst.op, opa, opb);   // holds while run low
        end
    end

    assign dout_n = inst.out_mask[mask_n] ? res : '0;
    assign dout_s = inst.out_mask[mask_s] ? res : '0;
    assign dout_w = inst.out_mask[mask_w] ? res : '0;
    assign dout_e = inst.out_mask[mask_e] ? res : '0;

endmodule

/* hdl/pe_c.sv */
`timescale 1ns/1ps

module pe_c
    import cgra_types_pkg::*;
    import cgra_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      init,
    input  logic      run,
    input  cfg_word_t inst_in,
    input  word_t     din_n,
    input  word_t     din_s,
    input  word_t     din_w,
    output word_t     dout_n,
    output word_t     dout_s,
    output word_t     dout_w
);

    pe_inst_t inst;
    word_t    res;
    word_t    opa;
    word_t    opb;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst <= '0;
        end else if (init) begin
            inst <= inst_in[$bits(cfg_word_t)-1 -: $bits(pe_inst_t)];
        end
    end

    // nothing east of the row end
    assign opa = pe_pick(inst.src_a, din_n, din_s, din_w, '0, res);
    assign opb = pe_pick(inst.src_b, din_n, din_s, din_w, '0, res);

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else if (run) begin
            res <= pe_alu(inst.op, opa, opb);
        end
    end

    assign dout_n = inst.out_mask[mask_n] ? res : '0;
    assign dout_s = inst.out_mask[mask_s] ? res : '0;
    assign dout_w = inst.out_mask[mask_w] ? res : '0;   // mask bit E unused

endmodule

/* hdl/lsu.sv */
`timescale 1ns/1ps

module lsu
    import cgra_types_pkg::*;
    import cgra_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      init,
    input  logic      run,
    input  cfg_word_t inst_in,
    input  word_t     pe_in,
    input  word_t     bank_rdata,
    output word_t     lsu_to_pe,
    output bank_req_t req
);

    lsu_inst_t inst;
    addr_t     count;
    logic      streaming;
    logic      rd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst <= '0;
        end else if (init) begin
            inst <= inst_in[$bits(lsu_inst_t)-1:0];   // low slice
        end
    end

    assign streaming = run && (inst.mode == lsu_load || inst.mode == lsu_store);

    // stream index, wraps at address width
    always_ff @(posedge clk) begin
        if (rst || init) begin
            count <= '0;
        end else if (streaming) begin
            count <= count + 1'b1;
        end
    end

    always_comb begin
        req.rd    = run && inst.mode == lsu_load;
        req.wr    = run && inst.mode == lsu_store;
        req.addr  = inst.base + count * inst.stride;   // strided address
        req.wdata = pe_in;
    end

    // bank answers one cycle after rd, then one more register
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_q      <= 1'b0;
            lsu_to_pe <= '0;
        end else begin
            rd_q <= req.rd;
            if (rd_q) begin
                lsu_to_pe <= bank_rdata;
            end
        end
    end

endmodule

/* hdl/pe_row.sv */
`timescale 1ns/1ps
`include "cgra_cfg.svh"

module pe_row
    import cgra_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       init_en,
    input  logic       run,
    input  logic [4:0] init_sel,
    input  cfg_word_t  pe_config,
    input  row_edge_t  n_in,
    input  row_edge_t  s_in,
    output row_edge_t  n_out,
    output row_edge_t  s_out,
    input  word_t      bank_rdata,
    output bank_req_t  req
);

    localparam int last = `CGRA_ROW_PES - 1;

    logic [4:0] init_unit;
    word_t [`CGRA_ROW_PES-1:0] n_in_w, s_in_w, n_out_w, s_out_w;
    word_t      w_in  [`CGRA_ROW_PES];   // west input of each element
    word_t      w_out [`CGRA_ROW_PES];   // west output of each element

    assign init_unit = init_sel & {5{init_en}};   // bit 4 lsu, bit 3 element 0
    assign n_in_w = n_in;
    assign s_in_w = s_in;
    assign n_out  = n_out_w;
    assign s_out  = s_out_w;

    lsu lsu_i (
        .clk        (clk),
        .rst        (rst),
        .init       (init_unit[4]),
        .run        (run),
        .inst_in    (pe_config),
        .pe_in      (w_out[0]),
        .bank_rdata (bank_rdata),
        .lsu_to_pe  (w_in[0]),
        .req        (req)
    );

    for (genvar i = 0; i < last; i++) begin : g_pe
        pe_d pe_d_i (
            .clk     (clk),
            .rst     (rst),
            .init    (init_unit[last-i]),
            .run     (run),
            .inst_in (pe_config),
            .din_n   (n_in_w[i]),
            .din_s   (s_in_w[i]),
            .din_w   (w_in[i]),
            .din_e   (w_out[i+1]),
            .dout_n  (n_out_w[i]),
            .dout_s  (s_out_w[i]),
            .dout_w  (w_out[i]),
            .dout_e  (w_in[i+1])
        );
    end

    pe_c pe_c_i (
        .clk     (clk),
        .rst     (rst),
        .init    (init_unit[0]),
        .run     (run),
        .inst_in (pe_config),
        .din_n   (n_in_w[last]),
        .din_s   (s_in_w[last]),
        .din_w   (w_in[last]),
        .dout_n  (n_out_w[last]),
        .dout_s  (s_out_w[last]),
        .dout_w  (w_out[last])
    );

endmodule

/* hdl/cbg_bank.sv */
`timescale 1ns/1ps
`include "cgra_cfg.svh"

module cbg_bank
    import cgra_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      run,
    input  bank_req_t req,
    input  logic      host_we,
    input  addr_t     host_addr,
    input  word_t     host_wdata,
    output word_t     rdata
);

    word_t mem [`CGRA_BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (req.wr) begin
            mem[req.addr] <= req.wdata;
        end else if (host_we && !run) begin
            mem[host_addr] <= host_wdata;   // preload only while stopped
        end
    end

    // one-cycle read
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (req.rd) begin
            rdata <= mem[req.addr];
        end
    end

endmodule

/* hdl/cgra_row_top.sv */
`timescale 1ns/1ps

module cgra_row_top
    import cgra_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       init_en,
    input  logic       run,
    input  logic [4:0] init_sel,
    input  cfg_word_t  pe_config,
    input  row_edge_t  n_in,
    input  row_edge_t  s_in,
    output row_edge_t  n_out,
    output row_edge_t  s_out,
    input  logic       host_we,
    input  addr_t      host_addr,
    input  word_t      host_wdata
);

    bank_req_t req;
    word_t     bank_rdata;

    pe_row pe_row_i (
        .clk        (clk),
        .rst        (rst),
        .init_en    (init_en),
        .run        (run),
        .init_sel   (init_sel),
        .pe_config  (pe_config),
        .n_in       (n_in),
        .s_in       (s_in),
        .n_out      (n_out),
        .s_out      (s_out),
        .bank_rdata (bank_rdata),
        .req        (req)
    );

    cbg_bank cbg_bank_i (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .req        (req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .rdata      (bank_rdata)
    );

endmodule

/* bench/cgra_row_props.sv */
`timescale 1ns/1ps

module cgra_row_props
    import cgra_types_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       run,
    input logic       init_en,
    input bank_req_t  req,
    input row_edge_t  n_out,
    input row_edge_t  s_out
);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(req.rd && req.wr))
        else $error("bank rd and wr strobes high together");

    a_req_needs_run: assert property (@(posedge clk) disable iff (rst) (req.rd || req.wr) |-> run)
        else $error("bank request issued while run is low");

    a_reset_clears: assert property (@(posedge clk) rst |=> (n_out == '0 && s_out == '0))
        else $error("row outputs not zero after reset");

    // no config capture and no result update without init_en or run
    a_init_gated: assert property (@(posedge clk)
        (!rst && !run && !init_en) |=> ($stable(n_out) && $stable(s_out)))
        else $error("row outputs changed with run and init_en low");

endmodule

bind pe_row cgra_row_props cgra_row_props_i (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .init_en (init_en),
    .req     (req),
    .n_out   (n_out),
    .s_out   (s_out)
);

/* bench/cgra_row_tb.sv */
`timescale 1ns/1ps
`include "cgra_cfg.svh"

module cgra_row_tb
    import cgra_types_pkg::*;
    import cgra_isa_pkg::*;
();

    localparam int max_cycles = 3000;   // stimulus is about 850 cycles

    logic       clk;
    logic       rst;
    logic       init_en;
    logic       run;
    logic [4:0] init_sel;
    cfg_word_t  pe_config;
    row_edge_t  n_in;
    row_edge_t  s_in;
    row_edge_t  n_out;
    row_edge_t  s_out;
    logic       host_we;
    addr_t      host_addr;
    word_t      host_wdata;

    pe_inst_t  m_inst [`CGRA_ROW_PES];   // reference model state
    word_t     m_res [`CGRA_ROW_PES];
    lsu_inst_t m_lsu;
    addr_t     m_count;
    logic      m_rdq;
    word_t     m_rdata;
    word_t     m_lsu_out;
    word_t     m_bank [`CGRA_BANK_DEPTH];
    word_t [`CGRA_ROW_PES-1:0] n_vec;
    word_t [`CGRA_ROW_PES-1:0] s_vec;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    cgra_row_top cgra_row_top_i (.*);

    assign n_vec = n_in;
    assign s_vec = s_in;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t apply_op(pe_op_e op, word_t a, word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_mul:  return a * b;   // wraps to the low word
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            default: return a;
        endcase
    endfunction

    function automatic word_t port_word(int i, int b);
        return m_inst[i].out_mask[b] ? m_res[i] : '0;
    endfunction

    function automatic word_t pick_operand(int i, port_sel_e sel);
        case (sel)
            sel_n:    return n_vec[i];
            sel_s:    return s_vec[i];
            sel_w:    return (i == 0) ? m_lsu_out : port_word(i - 1, mask_e);
            sel_e:    return (i == `CGRA_ROW_PES - 1) ? '0 : port_word(i + 1, mask_w);
            sel_self: return m_res[i];
            default:  return '0;
        endcase
    endfunction

    // mirrors every clock edge from the inputs seen before it
    always @(posedge clk) begin : model
        word_t nres [`CGRA_ROW_PES];
        logic  rd_now;
        logic  wr_now;
        addr_t a_now;
        for (int i = 0; i < `CGRA_ROW_PES; i++) begin
            nres[i] = apply_op(m_inst[i].op, pick_operand(i, m_inst[i].src_a),
                               pick_operand(i, m_inst[i].src_b));
        end
        rd_now = run && m_lsu.mode == lsu_load;
        wr_now = run && m_lsu.mode == lsu_store;
        a_now = m_lsu.base + m_count * m_lsu.stride;
        if (rst) begin
            for (int i = 0; i < `CGRA_ROW_PES; i++) begin
                m_inst[i] = '0;
                m_res[i] = '0;
            end
            m_lsu = '0;
            m_count = '0;
            m_rdq = 1'b0;
            m_rdata = '0;
            m_lsu_out = '0;
        end else begin
            if (m_rdq) m_lsu_out = m_rdata;   // second stage of the load path
            m_rdq = rd_now;
            if (rd_now) m_rdata = m_bank[a_now];
            if (wr_now) m_bank[a_now] = port_word(0, mask_w);
            else if (host_we && !run) m_bank[host_addr] = host_wdata;
            if (init_en && init_sel[4]) m_count = '0;
            else if (rd_now || wr_now) m_count = m_count + 8'd1;
            if (run) begin
                for (int i = 0; i < `CGRA_ROW_PES; i++) m_res[i] = nres[i];
            end
            for (int i = 0; i < `CGRA_ROW_PES; i++) begin
                if (init_en && init_sel[3-i]) m_inst[i] = pe_config[31:19];
            end
            if (init_en && init_sel[4]) m_lsu = pe_config[17:0];
        end
    end

    always @(negedge clk) begin : compare
        row_edge_t exp_n;
        row_edge_t exp_s;
        exp_n = {port_word(3, mask_n), port_word(2, mask_n), port_word(1, mask_n),
                 port_word(0, mask_n)};
        exp_s = {port_word(3, mask_s), port_word(2, mask_s), port_word(1, mask_s),
                 port_word(0, mask_s)};
        if (!rst) begin
            checks++;
            if (n_out !== exp_n) begin
                errors++;
                $display("FAILED at %0d ns: n_out %h, model %h", $time, n_out, exp_n);
            end
            if (s_out !== exp_s) begin
                errors++;
                $display("FAILED at %0d ns: s_out %h, model %h", $time, s_out, exp_s);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic cfg_word_t pe_word(pe_op_e op, port_sel_e a, port_sel_e b,
                                          logic [3:0] mask);
        return {op, a, b, mask, 19'b0};
    endfunction

    function automatic cfg_word_t lsu_word(lsu_mode_e mode, addr_t base, addr_t stride);
        return {14'b0, mode, base, stride};
    endfunction

    function automatic cfg_word_t random_pe_word(logic [3:0] mask);
        return pe_word(pe_op_e'(3'($urandom_range(0, 6))),
                       port_sel_e'(3'($urandom_range(0, 1))),
                       port_sel_e'(3'($urandom_range(0, 1))), mask);
    endfunction

    function automatic row_edge_t random_edge();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic step(input logic run_v, input row_edge_t nv, input row_edge_t sv);
        @(posedge clk);
        run     <= run_v;
        init_en <= 1'b0;
        host_we <= 1'b0;
        n_in    <= nv;
        s_in    <= sv;
    endtask

    task automatic configure(input logic en, input logic [4:0] sel, input cfg_word_t cfg);
        @(posedge clk);
        run       <= 1'b0;
        init_en   <= en;
        init_sel  <= sel;
        pe_config <= cfg;
        host_we   <= 1'b0;
    endtask

    task automatic host_write(input logic run_v, input addr_t a, input word_t d);
        @(posedge clk);
        run        <= run_v;
        init_en    <= 1'b0;
        host_we    <= 1'b1;
        host_addr  <= a;
        host_wdata <= d;
    endtask

    task automatic run_random(input int n);
        repeat (n) step(1'b1, random_edge(), random_edge());
    endtask

    initial begin
        addr_t base_v;
        addr_t stride_v;
        addr_t a_v;
        void'($urandom(81));
        rst        <= 1'b1;
        init_en    <= 1'b0;
        run        <= 1'b0;
        init_sel   <= '0;
        pe_config  <= '0;
        n_in       <= '0;
        s_in       <= '0;
        host_we    <= 1'b0;
        host_addr  <= '0;
        host_wdata <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // preload while stopped, outputs stay zero
        for (int a = 0; a < `CGRA_BANK_DEPTH; a++) host_write(1'b0, addr_t'(a), $urandom);
        for (int i = 0; i < `CGRA_ROW_PES; i++) configure(1'b1, 5'b01000 >> i, random_pe_word(4'b1100));
        run_random(200);
        configure(1'b1, 5'b01000, pe_word(op_add, sel_n, sel_w, 4'b1011));   // chain head
        configure(1'b1, 5'b00100, pe_word(op_xor, sel_w, sel_e, 4'b1011));
        configure(1'b1, 5'b00010, pe_word(op_pass, sel_w, sel_w, 4'b1011));
        configure(1'b1, 5'b00001, pe_word(op_add, sel_w, sel_e, 4'b1011));   // east is zero
        run_random(100);
        base_v = addr_t'($urandom);
        stride_v = addr_t'($urandom);
        configure(1'b1, 5'b01000, pe_word(op_pass, sel_n, sel_n, 4'b0010));
        configure(1'b1, 5'b10000, lsu_word(lsu_store, base_v, stride_v));
        run_random(50);
        configure(1'b1, 5'b01000, pe_word(op_pass, sel_w, sel_w, 4'b1000));
        configure(1'b1, 5'b10000, lsu_word(lsu_load, base_v, stride_v));
        run_random(54);
        for (int k = 0; k < `CGRA_ROW_PES; k++) begin
            configure(1'b0, 5'b11111, $urandom);   // init_en low
            configure(1'b1, 5'b01000 >> k, random_pe_word(4'b1100));
            run_random(20);
        end
        repeat (10) step(1'b0, random_edge(), random_edge());
        configure(1'b1, 5'b10000, lsu_word(lsu_idle, '0, '0));
        a_v = addr_t'($urandom);
        host_write(1'b1, a_v, $urandom);   // dropped, run is high
        configure(1'b1, 5'b01000, pe_word(op_pass, sel_w, sel_w, 4'b1000));
        configure(1'b1, 5'b10000, lsu_word(lsu_load, a_v, 8'd0));
        run_random(6);
        repeat (4) step(1'b0, '0, '0);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hdl
hdl/cgra_types_pkg.sv
hdl/cgra_isa_pkg.sv
hdl/pe_d.sv
hdl/pe_c.sv
hdl/lsu.sv
hdl/pe_row.sv
hdl/cbg_bank.sv
hdl/cgra_row_top.sv
bench/cgra_row_props.sv
bench/cgra_row_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CGRA row testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module cgra_row_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vcgra_row_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
